// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = id_stage_tb
FILELIST = vlog.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module id_stage_tb;

	localparam int N_LOAD = `NUM_REGS - 1;
	localparam int N_ALU = 150;
	localparam int N_FWD = 150;
	localparam int N_BR = 150;
	localparam int N_JMP = 80;
	localparam int N_BUB = 40;
	localparam int NUM_INST = N_LOAD + N_ALU + N_FWD + N_BR + N_JMP + N_BUB;

	// instruction classes for the generator
	localparam int GEN_ALU = 0;
	localparam int GEN_BRANCH = 1;
	localparam int GEN_JUMP = 2;
	localparam int GEN_BAD = 3;

	localparam logic [5:0] R_FUNCTS [10] = '{`FUNCT_AND, `FUNCT_OR, `FUNCT_XOR,
		`FUNCT_NOR, `FUNCT_ADD, `FUNCT_ADDU, `FUNCT_SUB, `FUNCT_SUBU, `FUNCT_SLT,
		`FUNCT_SLTU};
	localparam logic [5:0] SHIFT_FUNCTS [3] = '{`FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA};
	localparam logic [5:0] I_OPS [8] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
		`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
	// movn, movz, sync, sllv, srlv, srav
	localparam logic [5:0] BAD_FUNCTS [6] = '{6'b001011, 6'b001010, 6'b001111,
		6'b000100, 6'b000110, 6'b000111};

	typedef struct packed {
		logic                ex_wreg;
		mips_pkg::reg_addr_t ex_wd;
		mips_pkg::word_t     ex_wdata;
		logic                mem_wreg;
		mips_pkg::reg_addr_t mem_wd;
		mips_pkg::word_t     mem_wdata;
		logic                wb_we;
		mips_pkg::reg_addr_t wb_addr;
		mips_pkg::word_t     wb_data;
	} fwd_t;

	typedef struct packed {
		logic                valid;
		mips_pkg::alu_op_e   alu_op;
		mips_pkg::word_t     reg1;
		mips_pkg::word_t     reg2;
		mips_pkg::reg_addr_t wd;
		logic                wreg;
		logic                flag;
		mips_pkg::word_t     target;
		mips_pkg::word_t     link;
	} expect_t;

	logic                clk = 1'b0;
	logic                rst_i;
	logic                inst_valid_i;
	mips_pkg::word_t     pc_i;
	mips_pkg::inst_t     inst_i;
	logic                ex_wreg_i;
	mips_pkg::reg_addr_t ex_wd_i;
	mips_pkg::word_t     ex_wdata_i;
	logic                mem_wreg_i;
	mips_pkg::reg_addr_t mem_wd_i;
	mips_pkg::word_t     mem_wdata_i;
	logic                wb_we_i;
	mips_pkg::reg_addr_t wb_addr_i;
	mips_pkg::word_t     wb_data_i;
	logic                ex_valid_o;
	mips_pkg::alu_op_e   ex_alu_op_o;
	mips_pkg::word_t     ex_reg1_o;
	mips_pkg::word_t     ex_reg2_o;
	mips_pkg::reg_addr_t ex_wd_o;
	logic                ex_wreg_o;
	logic                branch_flag_o;
	mips_pkg::word_t     branch_target_o;
	mips_pkg::word_t     link_addr_o;

	integer          seed = 32'h31a5522d;
	mips_pkg::word_t model_regs [`NUM_REGS];
	expect_t         exp_q [$];
	int              checked = 0;

	always #5 clk = ~clk;

	id_stage id_stage_i (
		.clk             (clk),
		.rst_i           (rst_i),
		.inst_valid_i    (inst_valid_i),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.ex_wreg_i       (ex_wreg_i),
		.ex_wd_i         (ex_wd_i),
		.ex_wdata_i      (ex_wdata_i),
		.mem_wreg_i      (mem_wreg_i),
		.mem_wd_i        (mem_wd_i),
		.mem_wdata_i     (mem_wdata_i),
		.wb_we_i         (wb_we_i),
		.wb_addr_i       (wb_addr_i),
		.wb_data_i       (wb_data_i),
		.ex_valid_o      (ex_valid_o),
		.ex_alu_op_o     (ex_alu_op_o),
		.ex_reg1_o       (ex_reg1_o),
		.ex_reg2_o       (ex_reg2_o),
		.ex_wd_o         (ex_wd_o),
		.ex_wreg_o       (ex_wreg_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr_o)
	);

	// small values half the time, so equal, zero and negative operands are common
	function automatic mips_pkg::word_t rand_word();
		mips_pkg::word_t w;
		w = $random(seed);
		if (w[0]) begin
			return {{29{w[31]}}, w[3:1]};
		end
		return w;
	endfunction

	// aim forwarding at the source fields, at r0 or anywhere
	function automatic mips_pkg::reg_addr_t pick_reg(input mips_pkg::inst_t inst);
		mips_pkg::word_t w;
		w = $random(seed);
		case (w[1:0])
			2'd0: return inst[25:21];
			2'd1: return inst[20:16];
			2'd2: return '0;
			default: return w[8:4];
		endcase
	endfunction

	function automatic mips_pkg::inst_t rand_inst(input int kind);
		mips_pkg::word_t     w;
		mips_pkg::word_t     v;
		mips_pkg::word_t     u;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		mips_pkg::reg_addr_t rd;
		int                  sel;
		int                  idx;
		w = $random(seed);
		v = $random(seed);
		u = $random(seed);
		rs = w[4:0];
		rt = w[9:5];
		rd = w[14:10];
		sel = int'(v[7:0]);
		idx = int'(v[15:8]);
		case (kind)
			GEN_ALU: begin
				if (sel % 3 == 0) begin
					return {`OP_SPECIAL, rs, rt, rd, 5'd0, R_FUNCTS[idx % 10]};
				end else if (sel % 3 == 1) begin
					return {I_OPS[idx % 8], rs, rt, u[15:0]};
				end
				return {`OP_SPECIAL, 5'd0, rt, rd, w[19:15], SHIFT_FUNCTS[idx % 3]};
			end
			GEN_BRANCH: begin
				case (idx % 6)
					0: return {`OP_BEQ, rs, rt, u[15:0]};
					1: return {`OP_BNE, rs, rt, u[15:0]};
					2: return {`OP_BLEZ, rs, 5'd0, u[15:0]};
					3: return {`OP_BGTZ, rs, 5'd0, u[15:0]};
					4: return {`OP_REGIMM, rs, `RT_BLTZ, u[15:0]};
					default: return {`OP_REGIMM, rs, `RT_BGEZ, u[15:0]};
				endcase
			end
			GEN_JUMP: begin
				case (idx % 6)
					0: return {`OP_J, u[25:0]};
					1: return {`OP_JAL, u[25:0]};
					2: return {`OP_SPECIAL, rs, 5'd0, 5'd0, 5'd0, `FUNCT_JR};
					3: return {`OP_SPECIAL, rs, 5'd0, rd, 5'd0, `FUNCT_JALR};
					4: return {`OP_REGIMM, rs, `RT_BLTZAL, u[15:0]};
					default: return {`OP_REGIMM, rs, `RT_BGEZAL, u[15:0]};
				endcase
			end
			default: begin
				case (idx % 4)
					0: return {6'b100011, u[25:0]};
					1: return {6'b101011, u[25:0]};
					2: return {`OP_SPECIAL, rs, rt, rd, 5'd0, BAD_FUNCTS[sel % 6]};
					default: return {`OP_REGIMM, rs, 5'b00010, u[15:0]};
				endcase
			end
		endcase
	endfunction

	// ex before mem before write-back before the register array
	function automatic mips_pkg::word_t read_src(input mips_pkg::reg_addr_t addr,
			input fwd_t f);
		if (addr == '0) begin
			return '0;
		end else if (f.ex_wreg && (f.ex_wd == addr)) begin
			return f.ex_wdata;
		end else if (f.mem_wreg && (f.mem_wd == addr)) begin
			return f.mem_wdata;
		end else if (f.wb_we && (f.wb_addr == addr)) begin
			return f.wb_data;
		end
		return model_regs[addr];
	endfunction

	function automatic expect_t ref_decode(input logic valid, input mips_pkg::word_t pc,
			input mips_pkg::inst_t inst, input fwd_t f);
		expect_t             e;
		logic [5:0]          op;
		logic [5:0]          fn;
		mips_pkg::reg_addr_t rt;
		mips_pkg::word_t     a;
		mips_pkg::word_t     b;
		mips_pkg::word_t     sext;
		mips_pkg::word_t     zext;
		mips_pkg::word_t     pc4;
		logic                known;
		logic                cond;
		logic                itype;
		logic                link_wr;
		e = '0;
		known = 1'b1;
		cond = 1'b0;
		itype = 1'b0;
		link_wr = 1'b0;
		op = inst[31:26];
		fn = inst[5:0];
		rt = inst[20:16];
		a = read_src(inst[25:21], f);
		b = read_src(rt, f);
		sext = {{16{inst[15]}}, inst[15:0]};
		zext = {16'h0000, inst[15:0]};
		pc4 = pc + 32'd4;
		e.valid = 1'b1;
		case (op)
			`OP_SPECIAL: begin
				e.reg1 = a;
				e.reg2 = b;
				e.wd = inst[15:11];
				e.wreg = 1'b1;
				case (fn)
					`FUNCT_AND:  e.alu_op = mips_pkg::ALU_AND;
					`FUNCT_OR:   e.alu_op = mips_pkg::ALU_OR;
					`FUNCT_XOR:  e.alu_op = mips_pkg::ALU_XOR;
					`FUNCT_NOR:  e.alu_op = mips_pkg::ALU_NOR;
					`FUNCT_ADD:  e.alu_op = mips_pkg::ALU_ADD;
					`FUNCT_ADDU: e.alu_op = mips_pkg::ALU_ADDU;
					`FUNCT_SUB:  e.alu_op = mips_pkg::ALU_SUB;
					`FUNCT_SUBU: e.alu_op = mips_pkg::ALU_SUBU;
					`FUNCT_SLT:  e.alu_op = mips_pkg::ALU_SLT;
					`FUNCT_SLTU: e.alu_op = mips_pkg::ALU_SLTU;
					`FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA: begin
						e.alu_op = (fn == `FUNCT_SLL) ? mips_pkg::ALU_SLL :
							(fn == `FUNCT_SRL) ? mips_pkg::ALU_SRL : mips_pkg::ALU_SRA;
						e.reg1 = {27'd0, inst[10:6]};
					end
					`FUNCT_JR: begin
						e.reg2 = '0;
						e.wd = '0;
						e.wreg = 1'b0;
						e.flag = 1'b1;
						e.target = a;
					end
					`FUNCT_JALR: begin
						e.alu_op = mips_pkg::ALU_LINK;
						e.reg2 = '0;
						e.flag = 1'b1;
						e.target = a;
						e.link = pc + 32'd8;
					end
					default: known = 1'b0;
				endcase
			end
			`OP_REGIMM: begin
				e.reg1 = a;
				cond = 1'b1;
				e.flag = (rt == `RT_BLTZ || rt == `RT_BLTZAL) ? a[31] : !a[31];
				link_wr = (rt == `RT_BLTZAL || rt == `RT_BGEZAL);
				if (!(rt inside {`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL})) begin
					known = 1'b0;
				end
			end
			`OP_J, `OP_JAL: begin
				e.flag = 1'b1;
				e.target = {pc4[31:28], inst[25:0], 2'b00};
				link_wr = (op == `OP_JAL);
			end
			`OP_BEQ, `OP_BNE: begin
				e.reg1 = a;
				e.reg2 = b;
				cond = 1'b1;
				e.flag = (op == `OP_BEQ) ? (a == b) : (a != b);
			end
			`OP_BLEZ: begin
				e.reg1 = a;
				cond = 1'b1;
				e.flag = ($signed(a) <= 32'sd0);
			end
			`OP_BGTZ: begin
				e.reg1 = a;
				cond = 1'b1;
				e.flag = ($signed(a) > 32'sd0);
			end
			`OP_ADDI:  e.alu_op = mips_pkg::ALU_ADD;
			`OP_ADDIU: e.alu_op = mips_pkg::ALU_ADDU;
			`OP_SLTI:  e.alu_op = mips_pkg::ALU_SLT;
			`OP_SLTIU: e.alu_op = mips_pkg::ALU_SLTU;
			`OP_ANDI:  e.alu_op = mips_pkg::ALU_AND;
			`OP_ORI:   e.alu_op = mips_pkg::ALU_OR;
			`OP_XORI:  e.alu_op = mips_pkg::ALU_XOR;
			`OP_LUI:   e.alu_op = mips_pkg::ALU_LUI;
			default: known = 1'b0;
		endcase
		itype = op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
			`OP_XORI, `OP_LUI};
		if (itype) begin
			e.reg1 = (op == `OP_LUI) ? '0 : a;
			e.reg2 = (op inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI}) ? zext : sext;
			e.wd = rt;
			e.wreg = 1'b1;
		end
		if (link_wr) begin
			e.alu_op = mips_pkg::ALU_LINK;
			e.wd = `LINK_REG;
			e.wreg = 1'b1;
			e.link = pc + 32'd8;
		end
		if (cond && e.flag) begin
			e.target = pc4 + {sext[29:0], 2'b00};
		end
		if (!valid || !known) begin
			e = '0;
		end
		return e;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("ERROR %s expected 0x%08h got 0x%08h (result %0d)", name, exp_val,
			act_val, checked);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_ex(input logic exp_valid, input logic act_valid,
			input mips_pkg::alu_op_e exp_op, input mips_pkg::alu_op_e act_op,
			input mips_pkg::word_t exp_r1, input mips_pkg::word_t act_r1,
			input mips_pkg::word_t exp_r2, input mips_pkg::word_t act_r2,
			input mips_pkg::reg_addr_t exp_wd, input mips_pkg::reg_addr_t act_wd,
			input logic exp_wreg, input logic act_wreg);
		if (exp_valid !== act_valid)
			report_mismatch("ex_valid_o", 32'(exp_valid), 32'(act_valid));
		if (exp_op !== act_op)
			report_mismatch("ex_alu_op_o", 32'(exp_op), 32'(act_op));
		if (exp_r1 !== act_r1)
			report_mismatch("ex_reg1_o", exp_r1, act_r1);
		if (exp_r2 !== act_r2)
			report_mismatch("ex_reg2_o", exp_r2, act_r2);
		if (exp_wd !== act_wd)
			report_mismatch("ex_wd_o", 32'(exp_wd), 32'(act_wd));
		if (exp_wreg !== act_wreg)
			report_mismatch("ex_wreg_o", 32'(exp_wreg), 32'(act_wreg));
	endtask

	task automatic check_branch(input logic exp_flag, input logic act_flag,
			input mips_pkg::word_t exp_target, input mips_pkg::word_t act_target,
			input mips_pkg::word_t exp_link, input mips_pkg::word_t act_link);
		if (exp_flag !== act_flag)
			report_mismatch("branch_flag_o", 32'(exp_flag), 32'(act_flag));
		if (exp_target !== act_target)
			report_mismatch("branch_target_o", exp_target, act_target);
		if (exp_link !== act_link)
			report_mismatch("link_addr_o", exp_link, act_link);
	endtask

	// one instruction per falling edge with its expected result queued
	task automatic drive_cycle(input logic valid, input mips_pkg::inst_t inst,
			input logic use_fwd, input mips_pkg::reg_addr_t load_addr);
		fwd_t            f;
		mips_pkg::word_t w;
		mips_pkg::word_t pc;
		expect_t         e;
		w = $random(seed);
		pc = $random(seed);
		pc[1:0] = 2'b00;
		f.ex_wreg = use_fwd & w[0];
		f.ex_wd = pick_reg(inst);
		f.ex_wdata = rand_word();
		f.mem_wreg = use_fwd & w[1];
		f.mem_wd = pick_reg(inst);
		f.mem_wdata = rand_word();
		if (load_addr != '0) begin
			f.wb_we = 1'b1;
			f.wb_addr = load_addr;
		end else begin
			f.wb_we = w[2];
			f.wb_addr = use_fwd ? pick_reg(inst) : w[7:3];
		end
		f.wb_data = rand_word();
		inst_valid_i = valid;
		pc_i = pc;
		inst_i = inst;
		ex_wreg_i = f.ex_wreg;
		ex_wd_i = f.ex_wd;
		ex_wdata_i = f.ex_wdata;
		mem_wreg_i = f.mem_wreg;
		mem_wd_i = f.mem_wd;
		mem_wdata_i = f.mem_wdata;
		wb_we_i = f.wb_we;
		wb_addr_i = f.wb_addr;
		wb_data_i = f.wb_data;
		e = ref_decode(valid, pc, inst, f);
		exp_q.push_back(e);
		if (f.wb_we && (f.wb_addr != '0)) begin
			model_regs[f.wb_addr] = f.wb_data;
		end
		@(negedge clk);
	endtask

	// outputs settle right after the rising edge
	always @(posedge clk) begin : compare_results
		expect_t e;
		#1;
		if (rst_i) begin
			check_ex(1'b0, ex_valid_o, mips_pkg::ALU_NOP, ex_alu_op_o, '0, ex_reg1_o,
				'0, ex_reg2_o, '0, ex_wd_o, 1'b0, ex_wreg_o);
			check_branch(1'b0, branch_flag_o, '0, branch_target_o, '0, link_addr_o);
		end else if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			check_ex(e.valid, ex_valid_o, e.alu_op, ex_alu_op_o, e.reg1, ex_reg1_o,
				e.reg2, ex_reg2_o, e.wd, ex_wd_o, e.wreg, ex_wreg_o);
			check_branch(e.flag, branch_flag_o, e.target, branch_target_o, e.link,
				link_addr_o);
			checked++;
		end
	end

	initial begin : watchdog
		#((NUM_INST + 16 + 20) * 10);
		$display("timeout: the run did not finish in %0d cycles", NUM_INST + 36);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		mips_pkg::word_t w;
		rst_i = 1'b1;
		inst_valid_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		ex_wreg_i = 1'b0;
		ex_wd_i = '0;
		ex_wdata_i = '0;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
		wb_we_i = 1'b0;
		wb_addr_i = '0;
		wb_data_i = '0;
		for (int i = 0; i < `NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (16) @(negedge clk);
		rst_i = 1'b0;

		// fill the register file through write-back
		for (int r = 1; r < `NUM_REGS; r++) begin
			drive_cycle(1'b0, '0, 1'b0, mips_pkg::reg_addr_t'(r));
		end
		for (int i = 0; i < N_ALU; i++) begin
			drive_cycle(1'b1, rand_inst(GEN_ALU), 1'b0, '0);
		end
		for (int i = 0; i < N_FWD; i++) begin
			drive_cycle(1'b1, rand_inst(GEN_ALU), 1'b1, '0);
		end
		for (int i = 0; i < N_BR; i++) begin
			drive_cycle(1'b1, rand_inst(GEN_BRANCH), 1'b1, '0);
		end
		for (int i = 0; i < N_JMP; i++) begin
			drive_cycle(1'b1, rand_inst(GEN_JUMP), 1'b1, '0);
		end
		// invalid slots carry decodable code and valid ones undecoded code
		for (int i = 0; i < N_BUB; i++) begin
			w = $random(seed);
			drive_cycle(w[0], rand_inst(w[0] ? GEN_BAD : GEN_ALU), 1'b1, '0);
		end

		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== include/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// widths
`define WORD_W      32
`define REG_ADDR_W  5
`define SHAMT_W     5
`define IMM_W       16
`define IDX_W       26
`define NUM_REGS    32

// jal, bltzal and bgezal write here
`define LINK_REG    5'd31
`define RESET_PC    32'h0000_0000

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// special funct codes
`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_JR    6'b001000
`define FUNCT_JALR  6'b001001
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011

// regimm rt codes
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

`endif

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module branch_unit (
	input  logic              clk,
	input  logic              rst_i,
	id_dec_if.br              dec_i,
	input  logic [`IDX_W-1:0] index_i,
	input  mips_pkg::word_t   rs_val_i,
	input  mips_pkg::word_t   rt_val_i,
	output logic              branch_flag_o,
	output mips_pkg::word_t   branch_target_o,
	output mips_pkg::word_t   link_addr_o
);

	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t br_dest;
	mips_pkg::word_t jmp_dest;
	mips_pkg::word_t dest;
	logic            taken;
	logic            rs_zero;
	logic            rs_neg;

	assign pc_plus4 = dec_i.pc + 32'd4;
	assign br_dest  = pc_plus4 + {dec_i.imm[`WORD_W-3:0], 2'b00};
	// jump stays inside the 256MB region of the delay slot
	assign jmp_dest = {pc_plus4[`WORD_W-1 -: 4], index_i, 2'b00};
	assign rs_zero  = (rs_val_i == '0);
	assign rs_neg   = rs_val_i[`WORD_W-1];

	always_comb begin
		taken = 1'b0;
		dest  = br_dest;
		case (dec_i.br_kind)
			mips_pkg::BR_J: begin
				taken = 1'b1;
				dest  = jmp_dest;
			end
			mips_pkg::BR_JR: begin
				taken = 1'b1;
				dest  = rs_val_i;
			end
			mips_pkg::BR_BEQ:  taken = (rs_val_i == rt_val_i);
			mips_pkg::BR_BNE:  taken = (rs_val_i != rt_val_i);
			mips_pkg::BR_BLEZ: taken = rs_neg | rs_zero;
			mips_pkg::BR_BGTZ: taken = !rs_neg && !rs_zero;
			mips_pkg::BR_BLTZ: taken = rs_neg;
			mips_pkg::BR_BGEZ: taken = !rs_neg;
			default:           taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			branch_flag_o   <= 1'b0;
			branch_target_o <= `RESET_PC;
			link_addr_o     <= '0;
		end else begin
			branch_flag_o   <= taken;
			branch_target_o <= taken ? dest : `RESET_PC;
			// return past the delay slot, even when not taken
			link_addr_o     <= (dec_i.alu_op == mips_pkg::ALU_LINK) ? dec_i.pc + 32'd8 : '0;
		end
	end

endmodule

// ==== logic/id_ctrl.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module id_ctrl (
	input  logic              inst_valid_i,
	input  mips_pkg::word_t   pc_i,
	input  mips_pkg::inst_t   inst_i,
	output logic [`IDX_W-1:0] index_o,
	id_dec_if.ctrl            dec_o
);

	logic [5:0]          opcode;
	logic [5:0]          funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	mips_pkg::shamt_t    shamt;
	logic [`IMM_W-1:0]   imm16;
	mips_pkg::word_t     imm_sext;
	mips_pkg::word_t     imm_zext;
	mips_pkg::word_t     shamt_zext;

	logic                known;
	logic                itype;
	logic                link;
	logic                ok;
	mips_pkg::reg_addr_t rs_sel;
	mips_pkg::reg_addr_t rt_sel;
	logic                use_imm;
	mips_pkg::word_t     imm;
	mips_pkg::alu_op_e   alu_op;
	mips_pkg::reg_addr_t wd;
	logic                wreg;
	mips_pkg::br_kind_e  br_kind;

	assign opcode     = inst_i[31:26];
	assign rs         = inst_i[25:21];
	assign rt         = inst_i[20:16];
	assign rd         = inst_i[15:11];
	assign shamt      = inst_i[10:6];
	assign funct      = inst_i[5:0];
	assign imm16      = inst_i[`IMM_W-1:0];
	assign index_o    = inst_i[`IDX_W-1:0];
	assign imm_sext   = {{(`WORD_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
	assign imm_zext   = {{(`WORD_W-`IMM_W){1'b0}}, imm16};
	assign shamt_zext = {{(`WORD_W-`SHAMT_W){1'b0}}, shamt};

	// opcodes 001xxx are the immediate ALU group
	assign itype = (opcode[5:3] == 3'b001);

	always_comb begin
		known   = 1'b1;
		link    = 1'b0;
		rs_sel  = rs;
		rt_sel  = '0;
		use_imm = 1'b0;
		imm     = imm_sext;
		alu_op  = mips_pkg::ALU_NOP;
		wd      = rd;
		wreg    = 1'b0;
		br_kind = mips_pkg::BR_NONE;
		case (opcode)
			`OP_SPECIAL: begin
				rt_sel = rt;
				wreg   = 1'b1;
				case (funct)
					`FUNCT_AND:  alu_op = mips_pkg::ALU_AND;
					`FUNCT_OR:   alu_op = mips_pkg::ALU_OR;
					`FUNCT_XOR:  alu_op = mips_pkg::ALU_XOR;
					`FUNCT_NOR:  alu_op = mips_pkg::ALU_NOR;
					`FUNCT_ADD:  alu_op = mips_pkg::ALU_ADD;
					`FUNCT_ADDU: alu_op = mips_pkg::ALU_ADDU;
					`FUNCT_SUB:  alu_op = mips_pkg::ALU_SUB;
					`FUNCT_SUBU: alu_op = mips_pkg::ALU_SUBU;
					`FUNCT_SLT:  alu_op = mips_pkg::ALU_SLT;
					`FUNCT_SLTU: alu_op = mips_pkg::ALU_SLTU;
					`FUNCT_SLL:  alu_op = mips_pkg::ALU_SLL;
					`FUNCT_SRL:  alu_op = mips_pkg::ALU_SRL;
					`FUNCT_SRA:  alu_op = mips_pkg::ALU_SRA;
					`FUNCT_JR: begin
						rt_sel  = '0;
						wreg    = 1'b0;
						br_kind = mips_pkg::BR_JR;
					end
					// jalr links into rd, not r31
					`FUNCT_JALR: begin
						rt_sel  = '0;
						alu_op  = mips_pkg::ALU_LINK;
						br_kind = mips_pkg::BR_JR;
					end
					default: known = 1'b0;
				endcase
			end
			`OP_REGIMM: begin
				case (rt)
					`RT_BLTZ: br_kind = mips_pkg::BR_BLTZ;
					`RT_BGEZ: br_kind = mips_pkg::BR_BGEZ;
					`RT_BLTZAL: begin
						br_kind = mips_pkg::BR_BLTZ;
						link    = 1'b1;
					end
					`RT_BGEZAL: begin
						br_kind = mips_pkg::BR_BGEZ;
						link    = 1'b1;
					end
					default: known = 1'b0;
				endcase
			end
			`OP_J: begin
				rs_sel  = '0;
				br_kind = mips_pkg::BR_J;
			end
			`OP_JAL: begin
				rs_sel  = '0;
				br_kind = mips_pkg::BR_J;
				link    = 1'b1;
			end
			`OP_BEQ: begin
				rt_sel  = rt;
				br_kind = mips_pkg::BR_BEQ;
			end
			`OP_BNE: begin
				rt_sel  = rt;
				br_kind = mips_pkg::BR_BNE;
			end
			`OP_BLEZ:  br_kind = mips_pkg::BR_BLEZ;
			`OP_BGTZ:  br_kind = mips_pkg::BR_BGTZ;
			`OP_ADDI:  alu_op = mips_pkg::ALU_ADD;
			`OP_ADDIU: alu_op = mips_pkg::ALU_ADDU;
			`OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
			`OP_SLTIU: alu_op = mips_pkg::ALU_SLTU;
			`OP_ANDI:  alu_op = mips_pkg::ALU_AND;
			`OP_ORI:   alu_op = mips_pkg::ALU_OR;
			`OP_XORI:  alu_op = mips_pkg::ALU_XOR;
			`OP_LUI: begin
				rs_sel = '0;
				alu_op = mips_pkg::ALU_LUI;
			end
			default: known = 1'b0;
		endcase

		// shamt travels as the immediate, rs is not read
		if (alu_op inside {mips_pkg::ALU_SLL, mips_pkg::ALU_SRL, mips_pkg::ALU_SRA}) begin
			rs_sel  = '0;
			use_imm = 1'b1;
			imm     = shamt_zext;
		end
		// logical immediates and lui are zero extended (opcode bit 2)
		if (itype) begin
			use_imm = 1'b1;
			wd      = rt;
			wreg    = 1'b1;
			if (opcode[2]) begin
				imm = imm_zext;
			end
		end
		if (link) begin
			alu_op = mips_pkg::ALU_LINK;
			wd     = `LINK_REG;
			wreg   = 1'b1;
		end
	end

	// bubbles carry no operation, no write and no branch
	assign ok = inst_valid_i & known;

	assign dec_o.valid   = ok;
	assign dec_o.rs_addr = rs_sel;
	assign dec_o.rt_addr = rt_sel;
	assign dec_o.use_imm = use_imm;
	assign dec_o.imm     = imm;
	assign dec_o.alu_op  = ok ? alu_op : mips_pkg::ALU_NOP;
	assign dec_o.wd      = wd;
	assign dec_o.wreg    = ok & wreg;
	assign dec_o.br_kind = ok ? br_kind : mips_pkg::BR_NONE;
	assign dec_o.pc      = pc_i;

endmodule

// ==== logic/id_dec_if.sv ====
`timescale 1ns/1ps

interface id_dec_if;

	mips_pkg::reg_addr_t rs_addr;
	mips_pkg::reg_addr_t rt_addr;
	logic                use_imm;
	// already sign or zero extended
	mips_pkg::word_t     imm;
	mips_pkg::alu_op_e   alu_op;
	mips_pkg::reg_addr_t wd;
	logic                wreg;
	mips_pkg::br_kind_e  br_kind;
	mips_pkg::word_t     pc;
	logic                valid;

	modport ctrl (
		output rs_addr, rt_addr, use_imm, imm, alu_op, wd, wreg, br_kind, pc, valid
	);
	modport dp (
		input rs_addr, rt_addr, use_imm, imm, alu_op, wd, wreg, valid
	);
	modport br (
		input imm, alu_op, br_kind, pc
	);

endinterface

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module id_stage (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                inst_valid_i,
	input  mips_pkg::word_t     pc_i,
	input  mips_pkg::inst_t     inst_i,
	input  logic                ex_wreg_i,
	input  mips_pkg::reg_addr_t ex_wd_i,
	input  mips_pkg::word_t     ex_wdata_i,
	input  logic                mem_wreg_i,
	input  mips_pkg::reg_addr_t mem_wd_i,
	input  mips_pkg::word_t     mem_wdata_i,
	input  logic                wb_we_i,
	input  mips_pkg::reg_addr_t wb_addr_i,
	input  mips_pkg::word_t     wb_data_i,
	output logic                ex_valid_o,
	output mips_pkg::alu_op_e   ex_alu_op_o,
	output mips_pkg::word_t     ex_reg1_o,
	output mips_pkg::word_t     ex_reg2_o,
	output mips_pkg::reg_addr_t ex_wd_o,
	output logic                ex_wreg_o,
	output logic                branch_flag_o,
	output mips_pkg::word_t     branch_target_o,
	output mips_pkg::word_t     link_addr_o
);

	logic [`IDX_W-1:0] index;
	mips_pkg::word_t   rs_data;
	mips_pkg::word_t   rt_data;
	mips_pkg::word_t   rs_val;
	mips_pkg::word_t   rt_val;

	id_dec_if dec_if ();

	id_ctrl id_ctrl_i (
		.inst_valid_i (inst_valid_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.index_o      (index),
		.dec_o        (dec_if)
	);

	// write-back port goes straight into the register file
	reg_file reg_file_i (
		.clk      (clk),
		.rst_i    (rst_i),
		.we_i     (wb_we_i),
		.waddr_i  (wb_addr_i),
		.wdata_i  (wb_data_i),
		.raddr1_i (dec_if.rs_addr),
		.raddr2_i (dec_if.rt_addr),
		.rdata1_o (rs_data),
		.rdata2_o (rt_data)
	);

	operand_sel operand_sel_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.dec_i       (dec_if),
		.rs_data_i   (rs_data),
		.rt_data_i   (rt_data),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.rs_val_o    (rs_val),
		.rt_val_o    (rt_val),
		.ex_valid_o  (ex_valid_o),
		.ex_alu_op_o (ex_alu_op_o),
		.ex_reg1_o   (ex_reg1_o),
		.ex_reg2_o   (ex_reg2_o),
		.ex_wd_o     (ex_wd_o),
		.ex_wreg_o   (ex_wreg_o)
	);

	// condition sees the forwarded operands
	branch_unit branch_unit_i (
		.clk             (clk),
		.rst_i           (rst_i),
		.dec_i           (dec_if),
		.index_i         (index),
		.rs_val_i        (rs_val),
		.rt_val_i        (rt_val),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr_o)
	);

endmodule

// ==== logic/mips_pkg.sv ====
`include "mips_defs.svh"

package mips_pkg;

	typedef logic [`WORD_W-1:0]     word_t;
	typedef logic [`WORD_W-1:0]     inst_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`SHAMT_W-1:0]    shamt_t;

	// operation handed to the ex stage
	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_ADD,
		ALU_ADDU,
		ALU_SUB,
		ALU_SUBU,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_LINK
	} alu_op_e;

	// branch condition, link variants share the plain kind
	typedef enum logic [3:0] {
		BR_NONE,
		BR_J,
		BR_JR,
		BR_BEQ,
		BR_BNE,
		BR_BLEZ,
		BR_BGTZ,
		BR_BLTZ,
		BR_BGEZ
	} br_kind_e;

endpackage

// ==== logic/operand_sel.sv ====
`timescale 1ns/1ps

module operand_sel (
	input  logic                clk,
	input  logic                rst_i,
	id_dec_if.dp                dec_i,
	input  mips_pkg::word_t     rs_data_i,
	input  mips_pkg::word_t     rt_data_i,
	input  logic                ex_wreg_i,
	input  mips_pkg::reg_addr_t ex_wd_i,
	input  mips_pkg::word_t     ex_wdata_i,
	input  logic                mem_wreg_i,
	input  mips_pkg::reg_addr_t mem_wd_i,
	input  mips_pkg::word_t     mem_wdata_i,
	output mips_pkg::word_t     rs_val_o,
	output mips_pkg::word_t     rt_val_o,
	output logic                ex_valid_o,
	output mips_pkg::alu_op_e   ex_alu_op_o,
	output mips_pkg::word_t     ex_reg1_o,
	output mips_pkg::word_t     ex_reg2_o,
	output mips_pkg::reg_addr_t ex_wd_o,
	output logic                ex_wreg_o
);

	logic            is_shift;
	mips_pkg::word_t reg1_d;
	mips_pkg::word_t reg2_d;

	// youngest producer wins: ex, then mem, then the register file
	function automatic mips_pkg::word_t fwd(input mips_pkg::reg_addr_t addr,
			input mips_pkg::word_t rf_data);
		if (addr == '0) begin
			return '0;
		end else if (ex_wreg_i && (ex_wd_i == addr)) begin
			return ex_wdata_i;
		end else if (mem_wreg_i && (mem_wd_i == addr)) begin
			return mem_wdata_i;
		end
		return rf_data;
	endfunction

	always_comb begin
		rs_val_o = fwd(dec_i.rs_addr, rs_data_i);
		rt_val_o = fwd(dec_i.rt_addr, rt_data_i);
	end

	assign is_shift = dec_i.alu_op inside
		{mips_pkg::ALU_SLL, mips_pkg::ALU_SRL, mips_pkg::ALU_SRA};

	// shifts take shamt as reg1 and the rt value as reg2
	assign reg1_d = (dec_i.alu_op == mips_pkg::ALU_LUI) ? '0 :
		is_shift ? dec_i.imm : rs_val_o;
	assign reg2_d = (dec_i.use_imm && !is_shift) ? dec_i.imm : rt_val_o;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ex_valid_o  <= 1'b0;
			ex_alu_op_o <= mips_pkg::ALU_NOP;
			ex_reg1_o   <= '0;
			ex_reg2_o   <= '0;
			ex_wd_o     <= '0;
			ex_wreg_o   <= 1'b0;
		end else begin
			ex_valid_o  <= dec_i.valid;
			ex_alu_op_o <= dec_i.alu_op;
			ex_reg1_o   <= dec_i.valid ? reg1_d : '0;
			ex_reg2_o   <= dec_i.valid ? reg2_d : '0;
			ex_wd_o     <= dec_i.wreg ? dec_i.wd : '0;
			ex_wreg_o   <= dec_i.wreg;
		end
	end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                we_i,
	input  mips_pkg::reg_addr_t waddr_i,
	input  mips_pkg::word_t     wdata_i,
	input  mips_pkg::reg_addr_t raddr1_i,
	input  mips_pkg::reg_addr_t raddr2_i,
	output mips_pkg::word_t     rdata1_o,
	output mips_pkg::word_t     rdata2_o
);

	mips_pkg::word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// r0 reads zero, a write in the same cycle is passed through
	assign rdata1_o = (raddr1_i == '0) ? '0 :
		(we_i && (waddr_i == raddr1_i)) ? wdata_i :
		regs[raddr1_i];

	assign rdata2_o = (raddr2_i == '0) ? '0 :
		(we_i && (waddr_i == raddr2_i)) ? wdata_i :
		regs[raddr2_i];

endmodule

// ==== vlog.f ====
+incdir+include
logic/mips_pkg.sv
logic/id_dec_if.sv
logic/id_ctrl.sv
logic/reg_file.sv
logic/operand_sel.sv
logic/branch_unit.sv
logic/id_stage.sv
dv/id_stage_tb.sv
